// ==== mcpu_mem_pkg.sv ====
`default_nettype none

package mcpu_mem_pkg;

	typedef logic [31:0] word_t;     // data word
	typedef logic [31:0] paddr_t;    // byte address from the pipeline
	typedef logic [29:0] waddr_t;    // word address toward memory
	typedef logic [3:0]  byte_en_t;  // byte-write mask, zero for a read
	typedef logic [2:0]  mem_type_t; // {store, word, half}
	typedef logic [4:0]  rd_num_t;   // destination register
	typedef logic        port_sel_t; // arbiter port index

	function automatic logic is_store(mem_type_t t);
		return t[2];
	endfunction

	function automatic logic is_word(mem_type_t t);
		return t[1];
	endfunction

	// half only counts when the word bit is clear
	function automatic logic is_half(mem_type_t t);
		return t[0] & ~t[1];
	endfunction

endpackage

`default_nettype wire

// ==== mcpu_dc_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mcpu_dc_if;
	import mcpu_mem_pkg::*;

	waddr_t   paddr;    // word address
	byte_en_t write;    // byte-write mask
	logic     valid;    // request present
	word_t    data_out; // store data
	logic     done;     // request accepted this cycle
	word_t    data_in;  // read data of the last accepted request

	modport req (
		output paddr,
		output write,
		output valid,
		output data_out,
		input  done,
		input  data_in
	);

	modport rsp (
		input  paddr,
		input  write,
		input  valid,
		input  data_out,
		output done,
		output data_in
	);

endinterface

`default_nettype wire

// ==== mcpu_core_stage_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_core_stage_mem (
	input  logic                   clkrst_core_clk,
	input  logic                   clkrst_core_rst_n,
	input  logic                   valid_in,
	input  logic                   out_ok,
	input  mcpu_mem_pkg::paddr_t    paddr,
	input  mcpu_mem_pkg::word_t     data,
	input  mcpu_mem_pkg::mem_type_t mem_type,
	input  mcpu_mem_pkg::rd_num_t   rd_num,
	input  logic                   rd_we,
	output logic                   ready_in,
	output logic                   valid_out,
	output mcpu_mem_pkg::word_t     wb_data,
	output mcpu_mem_pkg::rd_num_t   wb_rd_num,
	output logic                   wb_rd_we,
	mcpu_dc_if.req                 dc
);
	import mcpu_mem_pkg::*;

	logic      in_progress; // result slot holds an accepted request
	mem_type_t type_q;
	logic [1:0] off_q;      // byte offset within the word
	rd_num_t   rd_num_q;
	logic      rd_we_q;

	assign dc.paddr = paddr[31:2];
	assign dc.valid = valid_in & out_ok; // nothing goes out under back-pressure

	// store lane formatting
	always_comb begin
		dc.write = '0;
		dc.data_out = data;
		if (is_store(mem_type)) begin
			if (is_word(mem_type)) begin
				dc.write = 4'b1111;
			end else if (is_half(mem_type)) begin
				dc.write = 4'b0011 << {paddr[1], 1'b0};
				dc.data_out = data << {paddr[1], 4'b0000};
			end else begin
				dc.write = 4'b0001 << paddr[1:0];
				dc.data_out = data << {paddr[1:0], 3'b000};
			end
		end
	end

	// slot advances on every done, even an idle one
	always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
		if (!clkrst_core_rst_n) begin
			in_progress <= 1'b0;
		end else if (dc.done) begin
			in_progress <= dc.valid;
		end
	end

	always_ff @(posedge clkrst_core_clk) begin
		if (dc.done) begin
			type_q <= mem_type;
			off_q <= paddr[1:0];
			rd_num_q <= rd_num;
			rd_we_q <= rd_we;
		end
	end

	// pull the addressed lanes down to bit 0, zero-extended
	always_comb begin
		if (is_word(type_q)) begin
			wb_data = dc.data_in;
		end else if (is_half(type_q)) begin
			wb_data = {16'h0000, dc.data_in[{off_q[1], 4'b0000} +: 16]};
		end else begin
			wb_data = {24'h00_0000, dc.data_in[{off_q, 3'b000} +: 8]};
		end
	end

	assign wb_rd_num = rd_num_q;
	assign wb_rd_we = rd_we_q;

	assign valid_out = dc.done & in_progress;
	assign ready_in = ~valid_in | (out_ok & dc.done);

endmodule

`default_nettype wire

// ==== mcpu_dc_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_dc_arbiter (
	input  logic   clkrst_core_clk,
	input  logic   clkrst_core_rst_n,
	mcpu_dc_if.rsp s0,
	mcpu_dc_if.rsp s1,
	mcpu_dc_if.req m
);
	import mcpu_mem_pkg::*;

	port_sel_t last_gnt; // port granted on the last grant
	port_sel_t gnt;
	logic      any_req;
	logic      rd_vld;   // memory returns data this cycle
	port_sel_t rd_port;  // owner of that data
	word_t     hold [2]; // per-port read data

	assign any_req = s0.valid | s1.valid;

	// round robin only matters on a tie
	always_comb begin
		if (s0.valid && s1.valid) begin
			gnt = ~last_gnt;
		end else if (s0.valid) begin
			gnt = 1'b0;
		end else begin
			gnt = 1'b1;
		end
	end

	assign m.valid = any_req;
	assign m.paddr = gnt ? s1.paddr : s0.paddr;
	assign m.write = gnt ? s1.write : s0.write;
	assign m.data_out = gnt ? s1.data_out : s0.data_out;

	assign s0.done = ~s0.valid | (~gnt & m.done);
	assign s1.done = ~s1.valid | (gnt & m.done);

	always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
		if (!clkrst_core_rst_n) begin
			last_gnt <= 1'b1; // port 0 wins the first tie
			rd_vld <= 1'b0;
			rd_port <= 1'b0;
		end else begin
			rd_vld <= any_req & m.done;
			rd_port <= gnt;
			if (any_req && m.done) begin
				last_gnt <= gnt;
			end
		end
	end

	always_ff @(posedge clkrst_core_clk) begin
		if (rd_vld) begin
			hold[rd_port] <= m.data_in;
		end
	end

	// live data right after the grant, held copy afterwards
	assign s0.data_in = (rd_vld && rd_port == 1'b0) ? m.data_in : hold[0];
	assign s1.data_in = (rd_vld && rd_port == 1'b1) ? m.data_in : hold[1];

endmodule

`default_nettype wire

// ==== mcpu_dmem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_dmem #(
	parameter int MEM_WORDS = 256
) (
	input  logic   clkrst_core_clk,
	input  logic   clkrst_core_rst_n,
	mcpu_dc_if.rsp m
);
	import mcpu_mem_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	word_t            mem [MEM_WORDS];
	logic [IDX_W-1:0] idx; // upper address bits wrap

	assign idx = m.paddr[IDX_W-1:0];

	// single port that never stalls
	assign m.done = 1'b1;

	// byte lanes written independently
	always_ff @(posedge clkrst_core_clk) begin
		if (m.valid && m.done) begin
			for (int b = 0; b < 4; b++) begin
				if (m.write[b]) begin
					mem[idx][8*b +: 8] <= m.data_out[8*b +: 8];
				end
			end
		end
	end

	// registered read, sees the word before this edge's write
	always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
		if (!clkrst_core_rst_n) begin
			m.data_in <= '0;
		end else if (m.valid && m.done) begin
			m.data_in <= mem[idx];
		end
	end

endmodule

`default_nettype wire

// ==== mcpu_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_mem_subsys #(
	parameter int MEM_WORDS = 256
) (
	input  logic                    clkrst_core_clk,
	input  logic                    clkrst_core_rst_n,

	input  logic                    p0_valid_in,
	input  logic                    p0_out_ok,
	input  mcpu_mem_pkg::paddr_t    p0_paddr,
	input  mcpu_mem_pkg::word_t     p0_data,
	input  mcpu_mem_pkg::mem_type_t p0_type,
	input  mcpu_mem_pkg::rd_num_t   p0_rd_num,
	input  logic                    p0_rd_we,
	output logic                    p0_ready_in,
	output logic                    p0_valid_out,
	output mcpu_mem_pkg::word_t     p0_wb_data,
	output mcpu_mem_pkg::rd_num_t   p0_wb_rd_num,
	output logic                    p0_wb_rd_we,

	input  logic                    p1_valid_in,
	input  logic                    p1_out_ok,
	input  mcpu_mem_pkg::paddr_t    p1_paddr,
	input  mcpu_mem_pkg::word_t     p1_data,
	input  mcpu_mem_pkg::mem_type_t p1_type,
	input  mcpu_mem_pkg::rd_num_t   p1_rd_num,
	input  logic                    p1_rd_we,
	output logic                    p1_ready_in,
	output logic                    p1_valid_out,
	output mcpu_mem_pkg::word_t     p1_wb_data,
	output mcpu_mem_pkg::rd_num_t   p1_wb_rd_num,
	output logic                    p1_wb_rd_we
);

	mcpu_dc_if dc0 (); // stage 0 to arbiter
	mcpu_dc_if dc1 (); // stage 1 to arbiter
	mcpu_dc_if dcm (); // arbiter to memory

	mcpu_core_stage_mem stage0_i (
		.clkrst_core_clk   (clkrst_core_clk),
		.clkrst_core_rst_n (clkrst_core_rst_n),
		.valid_in          (p0_valid_in),
		.out_ok            (p0_out_ok),
		.paddr             (p0_paddr),
		.data              (p0_data),
		.mem_type          (p0_type),
		.rd_num            (p0_rd_num),
		.rd_we             (p0_rd_we),
		.ready_in          (p0_ready_in),
		.valid_out         (p0_valid_out),
		.wb_data           (p0_wb_data),
		.wb_rd_num         (p0_wb_rd_num),
		.wb_rd_we          (p0_wb_rd_we),
		.dc                (dc0.req)
	);

	mcpu_core_stage_mem stage1_i (
		.clkrst_core_clk   (clkrst_core_clk),
		.clkrst_core_rst_n (clkrst_core_rst_n),
		.valid_in          (p1_valid_in),
		.out_ok            (p1_out_ok),
		.paddr             (p1_paddr),
		.data              (p1_data),
		.mem_type          (p1_type),
		.rd_num            (p1_rd_num),
		.rd_we             (p1_rd_we),
		.ready_in          (p1_ready_in),
		.valid_out         (p1_valid_out),
		.wb_data           (p1_wb_data),
		.wb_rd_num         (p1_wb_rd_num),
		.wb_rd_we          (p1_wb_rd_we),
		.dc                (dc1.req)
	);

	mcpu_dc_arbiter arb_i (
		.clkrst_core_clk   (clkrst_core_clk),
		.clkrst_core_rst_n (clkrst_core_rst_n),
		.s0                (dc0.rsp),
		.s1                (dc1.rsp),
		.m                 (dcm.req)
	);

	mcpu_dmem #(
		.MEM_WORDS (MEM_WORDS)
	) dmem_i (
		.clkrst_core_clk   (clkrst_core_clk),
		.clkrst_core_rst_n (clkrst_core_rst_n),
		.m                 (dcm.rsp)
	);

endmodule

`default_nettype wire

// ==== tb_mcpu_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mcpu_mem_subsys;
	import mcpu_mem_pkg::*;

	localparam int MEM_WORDS = 256;
	localparam int TIMEOUT = 20;
	localparam int N_RAND = 40;

	logic clkrst_core_clk = 1'b0;
	logic clkrst_core_rst_n;

	logic      [1:0]     valid_in;
	logic      [1:0]     out_ok;
	paddr_t    [1:0]     paddr;
	word_t     [1:0]     data;
	mem_type_t [1:0]     mtype;
	rd_num_t   [1:0]     rd_num;
	logic      [1:0]     rd_we;
	logic      [1:0]     ready_in;
	logic      [1:0]     valid_out;
	word_t     [1:0]     wb_data;
	rd_num_t   [1:0]     wb_rd_num;
	logic      [1:0]     wb_rd_we;

	logic [7:0] ref_mem [MEM_WORDS*4]; // byte-wide copy of the data memory
	word_t   [1:0] exp_data;
	rd_num_t [1:0] exp_rd;
	logic    [1:0] exp_load;
	int acc_cnt [2] = '{0, 0};
	int res_cnt [2] = '{0, 0};
	int acc_cyc [2] = '{0, 0};
	int cyc = 0;
	int seed;
	string test_name = "reset";

	logic   op_st   [2][N_RAND];
	int     op_kind [2][N_RAND]; // 0 byte, 1 half, 2 word
	paddr_t op_addr [2][N_RAND];
	word_t  op_data [2][N_RAND];

	mcpu_mem_subsys #(
		.MEM_WORDS (MEM_WORDS)
	) mcpu_mem_subsys_i (
		.clkrst_core_clk   (clkrst_core_clk),
		.clkrst_core_rst_n (clkrst_core_rst_n),
		.p0_valid_in  (valid_in[0]),
		.p0_out_ok    (out_ok[0]),
		.p0_paddr     (paddr[0]),
		.p0_data      (data[0]),
		.p0_type      (mtype[0]),
		.p0_rd_num    (rd_num[0]),
		.p0_rd_we     (rd_we[0]),
		.p0_ready_in  (ready_in[0]),
		.p0_valid_out (valid_out[0]),
		.p0_wb_data   (wb_data[0]),
		.p0_wb_rd_num (wb_rd_num[0]),
		.p0_wb_rd_we  (wb_rd_we[0]),
		.p1_valid_in  (valid_in[1]),
		.p1_out_ok    (out_ok[1]),
		.p1_paddr     (paddr[1]),
		.p1_data      (data[1]),
		.p1_type      (mtype[1]),
		.p1_rd_num    (rd_num[1]),
		.p1_rd_we     (rd_we[1]),
		.p1_ready_in  (ready_in[1]),
		.p1_valid_out (valid_out[1]),
		.p1_wb_data   (wb_data[1]),
		.p1_wb_rd_num (wb_rd_num[1]),
		.p1_wb_rd_we  (wb_rd_we[1])
	);

	always #2 clkrst_core_clk = ~clkrst_core_clk;

	always @(posedge clkrst_core_clk) begin
		cyc <= cyc + 1;
		for (int p = 0; p < 2; p++) begin
			if (valid_out[p]) begin
				res_cnt[p] <= res_cnt[p] + 1; // result consumed at this edge
			end
		end
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	for (genvar p = 0; p < 2; p++) begin : g_chk
		assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
			valid_out[p] |-> acc_cnt[p] != res_cnt[p])
		else report_failure($sformatf("port %0d raised valid_out with no request in flight", p));

		// one or two cycles from acceptance to the shown result
		assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
			valid_out[p] |-> cyc - acc_cyc[p] <= 1)
		else report_failure($sformatf("port %0d result came later than two cycles", p));

		assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
			valid_out[p] && exp_load[p] |-> wb_data[p] == exp_data[p])
		else report_failure($sformatf("FAILED %s port %0d wb_data expected %h actual %h",
			test_name, p, $sampled(exp_data[p]), $sampled(wb_data[p])));

		assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
			valid_out[p] |-> {wb_rd_num[p], wb_rd_we[p]} == {exp_rd[p], exp_load[p]})
		else report_failure($sformatf("FAILED %s port %0d rd_num/we expected %h actual %h",
			test_name, p, $sampled({exp_rd[p], exp_load[p]}),
			$sampled({wb_rd_num[p], wb_rd_we[p]})));

		assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
			valid_in[p] && !out_ok[p] |-> !ready_in[p] && !valid_out[p])
		else report_failure($sformatf("port %0d moved while out_ok was low", p));
	end

	function automatic int byte_idx(paddr_t a);
		return int'(a) & (MEM_WORDS * 4 - 1); // upper bits wrap
	endfunction

	task automatic ref_write(input paddr_t a, input word_t d, input int kind);
		int base;
		base = byte_idx(a);
		if (kind == 2) begin
			base = base & ~3;
			for (int b = 0; b < 4; b++) begin
				ref_mem[base + b] = d[8*b +: 8];
			end
		end else if (kind == 1) begin
			base = base & ~1; // lane pair from address bit 1
			ref_mem[base] = d[7:0];
			ref_mem[base + 1] = d[15:8];
		end else begin
			ref_mem[base] = d[7:0];
		end
	endtask

	function automatic word_t ref_read(paddr_t a, int kind);
		int base;
		word_t w;
		base = byte_idx(a);
		w = '0;
		if (kind == 2) begin
			base = base & ~3;
			w = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
		end else if (kind == 1) begin
			base = base & ~1;
			w[15:0] = {ref_mem[base + 1], ref_mem[base]};
		end else begin
			w[7:0] = ref_mem[base];
		end
		return w;
	endfunction

	task automatic wait_result(input int p);
		int n;
		n = 0;
		@(negedge clkrst_core_clk);
		while (!valid_out[p]) begin
			n++;
			if (n > TIMEOUT) report_failure($sformatf("port %0d stalled waiting for valid_out", p));
			@(negedge clkrst_core_clk);
		end
		@(posedge clkrst_core_clk);
		#0.5;
	endtask

	// with hold set the port keeps requesting and the next call drives on
	task automatic access(input int p, input logic st, input int kind, input paddr_t a,
			input word_t d, input rd_num_t rd, input logic hold);
		int n;
		valid_in[p] = 1'b1;
		paddr[p] = a;
		data[p] = d;
		mtype[p] = {st, kind == 2, kind == 1};
		rd_num[p] = rd;
		rd_we[p] = ~st;
		n = 0;
		@(negedge clkrst_core_clk);
		while (!ready_in[p]) begin
			n++;
			if (n > TIMEOUT) report_failure($sformatf("port %0d stalled waiting for ready_in", p));
			@(negedge clkrst_core_clk);
		end
		assert (n <= 1) else report_failure($sformatf("port %0d waited %0d cycles", p, n + 1));
		@(posedge clkrst_core_clk);
		#0.5;
		if (st) begin
			ref_write(a, d, kind);
		end else begin
			exp_data[p] = ref_read(a, kind);
		end
		exp_rd[p] = rd;
		exp_load[p] = ~st;
		acc_cyc[p] = cyc;
		acc_cnt[p]++;
		if (!hold) begin
			valid_in[p] = 1'b0;
			wait_result(p);
		end
	endtask

	task automatic run_stream(input int p);
		for (int i = 0; i < N_RAND; i++) begin
			access(p, op_st[p][i], op_kind[p][i], op_addr[p][i], op_data[p][i], 5'(i),
				i < N_RAND - 1);
		end
	endtask

	initial begin
		int r;
		seed = 32'h1156;
		valid_in = '0;
		out_ok = '1;
		paddr = '0;
		data = '0;
		mtype = '0;
		rd_num = '0;
		rd_we = '0;
		clkrst_core_rst_n = 1'b0;
		repeat (4) @(posedge clkrst_core_clk);
		#0.5;
		clkrst_core_rst_n = 1'b1;
		repeat (3) @(posedge clkrst_core_clk); // idle, no valid_out allowed
		#0.5;

		test_name = "word";
		access(0, 1'b1, 2, 32'h40, 32'hdead_beef, 5'd0, 1'b0);
		access(0, 1'b0, 2, 32'h40, '0, 5'd7, 1'b0);

		test_name = "lanes";
		access(0, 1'b1, 2, 32'h80, 32'h0, 5'd0, 1'b0);
		access(1, 1'b1, 2, 32'h84, 32'hffff_ffff, 5'd0, 1'b0);
		for (int b = 0; b < 4; b++) begin
			access(b % 2, 1'b1, 0, 32'h80 + b, $random(seed), 5'd0, 1'b0);
			access(b % 2, 1'b0, 2, 32'h80, '0, 5'(b + 1), 1'b0); // only one lane moved
			access(b % 2, 1'b0, 0, 32'h80 + b, '0, 5'(b + 8), 1'b0);
		end
		for (int h = 0; h < 2; h++) begin
			access(h, 1'b1, 1, 32'h84 + 2 * h, $random(seed), 5'd0, 1'b0);
			access(h, 1'b0, 2, 32'h84, '0, 5'(h + 16), 1'b0);
			access(h, 1'b0, 1, 32'h84 + 2 * h, '0, 5'(h + 20), 1'b0);
		end

		test_name = "shared";
		access(0, 1'b1, 2, 32'hc0, 32'h0bad_f00d, 5'd0, 1'b0);
		access(1, 1'b0, 2, 32'hc0, '0, 5'd11, 1'b0);
		access(1, 1'b1, 0, 32'hc3, 32'h0000_005a, 5'd0, 1'b0);
		access(0, 1'b0, 2, 32'hc0, '0, 5'd12, 1'b0);

		test_name = "contention";
		for (int i = 0; i < 16; i++) begin
			access(i % 2, 1'b1, 2, 32'h200 + 4 * i, $random(seed), 5'd0, 1'b0);
		end
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < N_RAND; i++) begin
				r = $random(seed);
				op_st[p][i] = r[0];
				op_kind[p][i] = int'(r[7:2]) % 3;
				op_addr[p][i] = 32'h200 + 32'(r[13:8]) + MEM_WORDS * 4 * (i % 3);
				op_data[p][i] = $random(seed);
			end
		end
		fork
			run_stream(0);
			run_stream(1);
		join

		test_name = "backpressure";
		access(0, 1'b1, 2, 32'h300, 32'h1234_5678, 5'd0, 1'b0);
		out_ok[0] = 1'b0;
		valid_in[0] = 1'b1;
		data[0] = 32'hffff_ffff;
		mtype[0] = 3'b110; // word store held back
		rd_we[0] = 1'b0;
		repeat (6) @(posedge clkrst_core_clk);
		#0.5;
		valid_in[0] = 1'b0;
		out_ok[0] = 1'b1;
		access(0, 1'b0, 2, 32'h300, '0, 5'd3, 1'b0);

		if (acc_cnt[0] != res_cnt[0] || acc_cnt[1] != res_cnt[1]) begin
			report_failure("a request never produced a result");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== mcpu_mem_subsys.f ====
mcpu_mem_pkg.sv
mcpu_dc_if.sv
mcpu_core_stage_mem.sv
mcpu_dc_arbiter.sv
mcpu_dmem.sv
mcpu_mem_subsys.sv
tb_mcpu_mem_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f mcpu_mem_subsys.f \
	--top-module tb_mcpu_mem_subsys > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_mcpu_mem_subsys > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation PASSED"
